// ==== build.f ====
hdl/rob_cfg_pkg.sv
hdl/rob_isa_pkg.sv
hdl/rob_dispatch.sv
hdl/rob_cdb_arbiter.sv
hdl/rob_branch_resolve.sv
hdl/rob_entry_store.sv
hdl/rob_top.sv
tb/rob_sva.sv
tb/rob_tb.sv

// ==== Makefile ====
# Verilator simulation of the reorder buffer testbench

VERILATOR ?= verilator
TOP       ?= rob_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb;
	import rob_cfg_pkg::*;
	import rob_isa_pkg::*;

	// the tests together run a few hundred cycles
	localparam int max_cycles = 4000;

	logic            clk;
	logic            rst;
	logic            disp_valid;
	opcode_t         disp_opcode;
	logic [XLEN-1:0] disp_pc;
	logic [4:0]      disp_rd;
	logic            disp_pred;
	logic [XLEN-1:0] disp_target;
	logic [2:0]      stall;
	logic [2:0]      src_valid;
	rob_tag_t        src_tag [3];
	logic [XLEN-1:0] src_data [3];
	logic            br_taken;
	logic [2:0]      src_ready;
	logic            disp_ready;
	rob_tag_t        disp_tag;
	logic            load_alu;
	logic            load_br;
	logic            load_lsq;
	logic            reg_write;
	logic            commit_valid;
	logic [4:0]      commit_rd;
	logic [XLEN-1:0] commit_data;
	logic            commit_reg_write;
	logic            flush;
	logic [XLEN-1:0] flush_pc;

	// reference model indexed by tag
	opcode_t         m_opc [ROB_DEPTH];
	logic [XLEN-1:0] m_pc [ROB_DEPTH];
	logic            m_pred [ROB_DEPTH];
	logic [XLEN-1:0] m_target [ROB_DEPTH];
	logic [4:0]      m_rd [ROB_DEPTH];
	logic            m_done [ROB_DEPTH];
	logic [XLEN-1:0] m_data [ROB_DEPTH];
	logic            m_flush [ROB_DEPTH];
	logic [XLEN-1:0] m_fpc [ROB_DEPTH];
	rob_tag_t        order_q [$];
	rob_tag_t        exp_tail;
	rob_tag_t        ctag;
	int              last_src;
	logic            gnt_seen;
	logic [31:0]     lcg_state;
	int              cycles = 0;
	string           test_name;

	rob_top #(
		.depth (ROB_DEPTH)
	) uut (
		.clk                (clk),
		.rst                (rst),
		.disp_valid_i       (disp_valid),
		.disp_opcode_i      (disp_opcode),
		.disp_pc_i          (disp_pc),
		.disp_rd_i          (disp_rd),
		.disp_pred_taken_i  (disp_pred),
		.disp_target_i      (disp_target),
		.stall_alu_i        (stall[SRC_ALU]),
		.stall_br_i         (stall[SRC_BR]),
		.stall_lsq_i        (stall[SRC_LSQ]),
		.disp_ready_o       (disp_ready),
		.disp_tag_o         (disp_tag),
		.load_alu_o         (load_alu),
		.load_br_o          (load_br),
		.load_lsq_o         (load_lsq),
		.reg_write_o        (reg_write),
		.alu_valid_i        (src_valid[SRC_ALU]),
		.alu_tag_i          (src_tag[SRC_ALU]),
		.alu_data_i         (src_data[SRC_ALU]),
		.alu_ready_o        (src_ready[SRC_ALU]),
		.br_valid_i         (src_valid[SRC_BR]),
		.br_tag_i           (src_tag[SRC_BR]),
		.br_data_i          (src_data[SRC_BR]),
		.br_taken_i         (br_taken),
		.br_ready_o         (src_ready[SRC_BR]),
		.lsq_valid_i        (src_valid[SRC_LSQ]),
		.lsq_tag_i          (src_tag[SRC_LSQ]),
		.lsq_data_i         (src_data[SRC_LSQ]),
		.lsq_ready_o        (src_ready[SRC_LSQ]),
		.commit_valid_o     (commit_valid),
		.commit_rd_o        (commit_rd),
		.commit_data_o      (commit_data),
		.commit_reg_write_o (commit_reg_write),
		.flush_o            (flush),
		.flush_pc_o         (flush_pc)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped");
	endtask

	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (exp == act) else begin
			$display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int source_for(opcode_t opc);
		if (opc inside {op_jal, op_jalr, op_br})
			return SRC_BR;
		if (opc inside {op_load, op_store})
			return SRC_LSQ;
		return SRC_ALU;
	endfunction

	// hold the request until ready is seen at a falling edge
	task automatic dispatch_one(input opcode_t opc, input logic [4:0] rd,
			input logic [XLEN-1:0] pc, input logic pred, input logic [XLEN-1:0] target,
			output rob_tag_t tag);
		logic done;
		done        = 1'b0;
		disp_valid  = 1'b1;
		disp_opcode = opc;
		disp_pc     = pc;
		disp_rd     = rd;
		disp_pred   = pred;
		disp_target = target;
		while (!done) begin
			@(negedge clk);
			if (disp_ready) begin
				done = 1'b1;
				tag  = disp_tag;
				check_eq("dispatch tag", 32'(exp_tail), 32'(disp_tag));
				check_eq("station load", 32'(3'b001 << source_for(opc)),
					32'({load_lsq, load_br, load_alu}));
				check_eq("reg write", 32'(!(opc inside {op_br, op_store})), 32'(reg_write));
				m_opc[tag]    = opc;
				m_pc[tag]     = pc;
				m_pred[tag]   = pred;
				m_target[tag] = target;
				m_rd[tag]     = rd;
				m_done[tag]   = 1'b0;
				order_q.push_back(tag);
				exp_tail = rob_tag_t'((int'(exp_tail) + 1) % ROB_DEPTH);
			end
			@(posedge clk);
			#2;
		end
		disp_valid = 1'b0;
	endtask

	// expected commit fields once a result is accepted
	task automatic expect_result(input rob_tag_t tag, input logic [XLEN-1:0] data,
			input logic taken);
		logic [XLEN-1:0] link;
		link         = m_pc[tag] + 32'd4;
		m_done[tag]  = 1'b1;
		m_data[tag]  = data;
		m_flush[tag] = 1'b0;
		m_fpc[tag]   = '0;
		if (m_opc[tag] == op_jal) begin
			m_data[tag] = link;
		end else if (m_opc[tag] == op_jalr) begin
			m_data[tag]  = link;
			m_flush[tag] = 1'b1;
			m_fpc[tag]   = data;
		end else if (m_opc[tag] == op_br && taken != m_pred[tag]) begin
			m_flush[tag] = 1'b1;
			m_fpc[tag]   = taken ? m_target[tag] : link;
		end
	endtask

	task automatic complete_one(input int src, input rob_tag_t tag, input logic [XLEN-1:0] data,
			input logic taken);
		logic done;
		done           = 1'b0;
		src_valid[src] = 1'b1;
		src_tag[src]   = tag;
		src_data[src]  = data;
		if (src == SRC_BR)
			br_taken = taken;
		while (!done) begin
			@(negedge clk);
			if (src_ready[src]) begin
				done = 1'b1;
				expect_result(tag, data, taken);
			end
			@(posedge clk);
			#2;
		end
		src_valid[src] = 1'b0;
	endtask

	task automatic drain_commits();
		while (order_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	// commit side of the model
	always @(negedge clk) begin
		if (!rst) begin
			if (flush)
				check_eq("ready in flush cycle", 32'd0, 32'(disp_ready));
			if (commit_valid) begin
				assert (order_q.size() != 0) else begin
					$display("commit seen with no instruction outstanding");
					abort_run();
				end
				ctag = order_q.pop_front();
				assert (m_done[ctag]) else begin
					$display("entry committed before its result was accepted");
					abort_run();
				end
				check_eq("commit rd", 32'(m_rd[ctag]), 32'(commit_rd));
				check_eq("commit reg_write", 32'(!(m_opc[ctag] inside {op_br, op_store})),
					32'(commit_reg_write));
				check_eq("commit data", m_data[ctag], commit_data);
				check_eq("commit flush", 32'(m_flush[ctag]), 32'(flush));
				if (m_flush[ctag]) begin
					check_eq("flush pc", m_fpc[ctag], flush_pc);
					order_q.delete();
					exp_tail = '0;
				end
			end else begin
				check_eq("flush without commit", 32'd0, 32'(flush));
			end
		end
	end

	// round-robin model of the completion grant
	always @(negedge clk) begin
		int next_src;
		if (rst) begin
			gnt_seen = 1'b0;
			last_src = 0;
		end else if (src_ready != 3'b000) begin
			// the first waiting source after the previous winner
			next_src = (last_src + 1) % 3;
			while (!src_valid[next_src] && next_src != last_src)
				next_src = (next_src + 1) % 3;
			if (gnt_seen)
				check_eq("grant order", 32'(3'b001 << next_src), 32'(src_ready));
			gnt_seen = 1'b1;
			for (int s = 0; s < 3; s++) begin
				if (src_ready[s])
					last_src = s;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			abort_run();
		end
	end

	task automatic check_reset_state();
		test_name = "reset";
		@(negedge clk);
		check_eq("outputs after reset", 32'd1, 32'({commit_valid, flush, src_ready,
			load_alu, load_br, load_lsq, disp_ready}));
		@(posedge clk);
		#2;
	endtask

	task automatic stall_gating();
		opcode_t ops [3];
		ops       = '{op_reg, op_br, op_load};
		test_name = "stall";
		for (int s = 0; s < 3; s++) begin
			stall = 3'b001 << s;
			for (int k = 0; k < 3; k++) begin
				disp_opcode = ops[k];
				@(negedge clk);
				check_eq("ready under stall", 32'(k != s), 32'(disp_ready));
				@(posedge clk);
				#2;
			end
		end
		stall = '0;
	endtask

	task automatic shuffled_completion();
		opcode_t         ops [6];
		rob_tag_t        tags [6];
		int              order [6];
		int              pick;
		int              tmp;
		logic [XLEN-1:0] r;
		ops       = '{op_reg, op_imm, op_lui, op_auipc, op_load, op_store};
		test_name = "in_order";
		for (int round = 0; round < 3; round++) begin
			for (int i = 0; i < 6; i++) begin
				r    = rand_next();
				pick = int'(r % 32'd6);
				dispatch_one(ops[pick], r[12:8], r & 32'h0000_fffc, 1'b0, '0, tags[i]);
				order[i] = i;
			end
			for (int i = 5; i > 0; i--) begin
				pick     = int'(rand_next() % 32'(i + 1));
				tmp      = order[i];
				order[i] = order[pick];
				order[pick] = tmp;
			end
			for (int i = 0; i < 6; i++)
				complete_one(source_for(m_opc[tags[order[i]]]), tags[order[i]], rand_next(), 1'b0);
			drain_commits();
		end
	endtask

	task automatic fill_to_full();
		rob_tag_t t [ROB_DEPTH];
		test_name = "full";
		for (int i = 0; i < ROB_DEPTH; i++)
			dispatch_one(op_reg, 5'(i + 1), 32'(i * 4), 1'b0, '0, t[i]);
		@(negedge clk);
		check_eq("ready when full", 32'd0, 32'(disp_ready));
		@(posedge clk);
		#2;
		complete_one(SRC_ALU, t[0], 32'h1000, 1'b0);
		@(negedge clk);
		while (!commit_valid)
			@(negedge clk);
		check_eq("ready on commit while full", 32'd1, 32'(disp_ready));
		@(posedge clk);
		#2;
		for (int i = 1; i < ROB_DEPTH; i++)
			complete_one(SRC_ALU, t[i], 32'(i), 1'b0);
		drain_commits();
	endtask

	// all three sources raise valid in the same cycle
	task automatic contend_sources();
		rob_tag_t ta;
		rob_tag_t tbr;
		rob_tag_t tl;
		test_name = "arbitration";
		for (int round = 0; round < 2; round++) begin
			dispatch_one(op_reg, 5'd3, 32'h100, 1'b0, '0, ta);
			dispatch_one(op_br, 5'd0, 32'h104, 1'b0, 32'h200, tbr);
			dispatch_one(op_load, 5'd4, 32'h108, 1'b0, '0, tl);
			fork
				complete_one(SRC_ALU, ta, 32'haaaa, 1'b0);
				complete_one(SRC_BR, tbr, 32'h0, 1'b0);
				complete_one(SRC_LSQ, tl, 32'h5555, 1'b0);
			join
			drain_commits();
		end
	endtask

	task automatic jump_links();
		rob_tag_t        t;
		logic [XLEN-1:0] r;
		test_name = "jump";
		for (int i = 0; i < 4; i++) begin
			r = rand_next();
			dispatch_one(op_jal, r[4:0], r & 32'h0000_fffc, 1'b1, '0, t);
			complete_one(SRC_BR, t, rand_next(), 1'b1);
			drain_commits();
		end
	endtask

	// taken misprediction, not-taken misprediction, then jalr
	task automatic redirect_flush();
		rob_tag_t        t_old;
		rob_tag_t        t_young;
		logic [XLEN-1:0] r;
		test_name = "redirect";
		for (int i = 0; i < 3; i++) begin
			r = rand_next() & 32'h0000_fffc;
			if (i == 2)
				dispatch_one(op_jalr, 5'd1, r, 1'b0, '0, t_old);
			else
				dispatch_one(op_br, 5'd0, r, i == 1, r + 32'h40, t_old);
			dispatch_one(op_reg, 5'd7, r + 32'd4, 1'b0, '0, t_young);
			complete_one(SRC_ALU, t_young, 32'hdead, 1'b0);
			complete_one(SRC_BR, t_old, r + 32'h80, i == 0);
			drain_commits();
			repeat (4) @(posedge clk);
			#2;
			dispatch_one(op_imm, 5'd2, 32'h10, 1'b0, '0, t_old);
			complete_one(SRC_ALU, t_old, 32'h1, 1'b0);
			drain_commits();
		end
	endtask

	initial begin
		lcg_state   = 32'd85;
		rst         = 1'b1;
		disp_valid  = 1'b0;
		disp_opcode = op_imm;
		disp_pc     = '0;
		disp_rd     = '0;
		disp_pred   = 1'b0;
		disp_target = '0;
		stall       = '0;
		src_valid   = '0;
		br_taken    = 1'b0;
		exp_tail    = '0;
		for (int i = 0; i < 3; i++) begin
			src_tag[i]  = '0;
			src_data[i] = '0;
		end
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		check_reset_state();
		stall_gating();
		shuffled_completion();
		fill_to_full();
		contend_sources();
		jump_links();
		redirect_flush();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== tb/rob_sva.sv ====
`timescale 1ns/1ps

module rob_sva (
	input logic                         clk,
	input logic                         rst,
	input logic                         disp_valid_i,
	input logic                         disp_ready_o,
	input logic                         commit_valid_o,
	input logic                         flush_o,
	input logic                         alu_valid_i,
	input rob_cfg_pkg::rob_tag_t        alu_tag_i,
	input logic [rob_cfg_pkg::XLEN-1:0] alu_data_i,
	input logic                         alu_ready_o,
	input logic                         br_valid_i,
	input rob_cfg_pkg::rob_tag_t        br_tag_i,
	input logic [rob_cfg_pkg::XLEN-1:0] br_data_i,
	input logic                         br_taken_i,
	input logic                         br_ready_o,
	input logic                         lsq_valid_i,
	input rob_cfg_pkg::rob_tag_t        lsq_tag_i,
	input logic [rob_cfg_pkg::XLEN-1:0] lsq_data_i,
	input logic                         lsq_ready_o
);
	logic seen_disp;

	always_ff @(posedge clk) begin
		if (rst) begin
			seen_disp <= 1'b0;
		end else if (disp_valid_i && disp_ready_o) begin
			seen_disp <= 1'b1;
		end
	end

	quiet_until_dispatch: assert property (@(posedge clk) disable iff (rst)
		!seen_disp |-> !commit_valid_o && !flush_o)
		else $error("commit or flush before the first dispatch");

	one_grant: assert property (@(posedge clk) disable iff (rst)
		$onehot0({alu_ready_o, br_ready_o, lsq_ready_o}))
		else $error("more than one completion ready in a cycle");

	// a waiting source keeps valid and payload
	alu_hold: assert property (@(posedge clk) disable iff (rst)
		alu_valid_i && !alu_ready_o |=> alu_valid_i && $stable(alu_tag_i) && $stable(alu_data_i))
		else $error("alu completion changed while waiting");

	br_hold: assert property (@(posedge clk) disable iff (rst)
		br_valid_i && !br_ready_o |=> br_valid_i && $stable(br_tag_i) && $stable(br_data_i)
		&& $stable(br_taken_i))
		else $error("branch completion changed while waiting");

	lsq_hold: assert property (@(posedge clk) disable iff (rst)
		lsq_valid_i && !lsq_ready_o |=> lsq_valid_i && $stable(lsq_tag_i) && $stable(lsq_data_i))
		else $error("load/store completion changed while waiting");

endmodule

bind rob_top rob_sva u_sva (.*);

// ==== hdl/rob_top.sv ====
`timescale 1ns/1ps

module rob_top #(
	parameter int depth = rob_cfg_pkg::ROB_DEPTH
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         disp_valid_i,
	input  rob_isa_pkg::opcode_t         disp_opcode_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] disp_pc_i,
	input  logic [4:0]                   disp_rd_i,
	input  logic                         disp_pred_taken_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] disp_target_i,
	input  logic                         stall_alu_i,
	input  logic                         stall_br_i,
	input  logic                         stall_lsq_i,
	output logic                         disp_ready_o,
	output rob_cfg_pkg::rob_tag_t        disp_tag_o,
	output logic                         load_alu_o,
	output logic                         load_br_o,
	output logic                         load_lsq_o,
	output logic                         reg_write_o,
	input  logic                         alu_valid_i,
	input  rob_cfg_pkg::rob_tag_t        alu_tag_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] alu_data_i,
	output logic                         alu_ready_o,
	input  logic                         br_valid_i,
	input  rob_cfg_pkg::rob_tag_t        br_tag_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] br_data_i,
	input  logic                         br_taken_i,
	output logic                         br_ready_o,
	input  logic                         lsq_valid_i,
	input  rob_cfg_pkg::rob_tag_t        lsq_tag_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] lsq_data_i,
	output logic                         lsq_ready_o,
	output logic                         commit_valid_o,
	output logic [4:0]                   commit_rd_o,
	output logic [rob_cfg_pkg::XLEN-1:0] commit_data_o,
	output logic                         commit_reg_write_o,
	output logic                         flush_o,
	output logic [rob_cfg_pkg::XLEN-1:0] flush_pc_o
);
	import rob_cfg_pkg::*;
	import rob_isa_pkg::*;

	logic            full;
	logic            alloc;
	logic [2:0]      req;
	logic [2:0]      gnt;
	rob_tag_t        src_tag [3];
	logic [XLEN-1:0] src_data [3];
	logic            wr_valid;
	rob_tag_t        wr_tag;
	logic [XLEN-1:0] wr_data;
	logic            wr_is_br;
	logic            wr_taken;
	opcode_t         ent_opcode;
	logic [XLEN-1:0] ent_pc;
	logic            ent_pred;
	logic [XLEN-1:0] ent_target;
	logic [XLEN-1:0] res_data;
	logic            res_redirect;
	logic [XLEN-1:0] res_pc;

	assign req[SRC_ALU]      = alu_valid_i;
	assign req[SRC_BR]       = br_valid_i;
	assign req[SRC_LSQ]      = lsq_valid_i;
	assign src_tag[SRC_ALU]  = alu_tag_i;
	assign src_tag[SRC_BR]   = br_tag_i;
	assign src_tag[SRC_LSQ]  = lsq_tag_i;
	assign src_data[SRC_ALU] = alu_data_i;
	assign src_data[SRC_BR]  = br_data_i;
	assign src_data[SRC_LSQ] = lsq_data_i;
	assign alu_ready_o       = gnt[SRC_ALU];
	assign br_ready_o        = gnt[SRC_BR];
	assign lsq_ready_o       = gnt[SRC_LSQ];

	rob_dispatch u_dispatch (
		.disp_valid_i  (disp_valid_i),
		.disp_opcode_i (disp_opcode_i),
		.stall_alu_i   (stall_alu_i),
		.stall_br_i    (stall_br_i),
		.stall_lsq_i   (stall_lsq_i),
		.full_i        (full),
		.flush_i       (flush_o),
		.disp_ready_o  (disp_ready_o),
		.alloc_o       (alloc),
		.load_alu_o    (load_alu_o),
		.load_br_o     (load_br_o),
		.load_lsq_o    (load_lsq_o),
		.reg_write_o   (reg_write_o)
	);

	rob_cdb_arbiter #(
		.depth (depth)
	) u_arbiter (
		.clk        (clk),
		.rst        (rst),
		.req_i      (req),
		.tag_i      (src_tag),
		.data_i     (src_data),
		.taken_i    (br_taken_i),
		.gnt_o      (gnt),
		.wr_valid_o (wr_valid),
		.wr_tag_o   (wr_tag),
		.wr_data_o  (wr_data),
		.wr_is_br_o (wr_is_br),
		.wr_taken_o (wr_taken)
	);

	rob_branch_resolve u_resolve (
		.wr_valid_i     (wr_valid),
		.wr_is_br_i     (wr_is_br),
		.wr_data_i      (wr_data),
		.wr_taken_i     (wr_taken),
		.ent_opcode_i   (ent_opcode),
		.ent_pc_i       (ent_pc),
		.ent_pred_i     (ent_pred),
		.ent_target_i   (ent_target),
		.res_data_o     (res_data),
		.res_redirect_o (res_redirect),
		.res_pc_o       (res_pc)
	);

	rob_entry_store #(
		.depth (depth)
	) u_store (
		.clk                (clk),
		.rst                (rst),
		.alloc_i            (alloc),
		.alloc_opcode_i     (disp_opcode_i),
		.alloc_pc_i         (disp_pc_i),
		.alloc_rd_i         (disp_rd_i),
		.alloc_pred_i       (disp_pred_taken_i),
		.alloc_target_i     (disp_target_i),
		.alloc_reg_write_i  (reg_write_o),
		.wr_valid_i         (wr_valid),
		.wr_tag_i           (wr_tag),
		.res_data_i         (res_data),
		.res_redirect_i     (res_redirect),
		.res_pc_i           (res_pc),
		.full_o             (full),
		.tail_o             (disp_tag_o),
		.ent_opcode_o       (ent_opcode),
		.ent_pc_o           (ent_pc),
		.ent_pred_o         (ent_pred),
		.ent_target_o       (ent_target),
		.commit_valid_o     (commit_valid_o),
		.commit_rd_o        (commit_rd_o),
		.commit_data_o      (commit_data_o),
		.commit_reg_write_o (commit_reg_write_o),
		.flush_o            (flush_o),
		.flush_pc_o         (flush_pc_o)
	);

endmodule

// ==== hdl/rob_entry_store.sv ====
`timescale 1ns/1ps

module rob_entry_store #(
	parameter int depth = rob_cfg_pkg::ROB_DEPTH
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         alloc_i,
	input  rob_isa_pkg::opcode_t         alloc_opcode_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] alloc_pc_i,
	input  logic [4:0]                   alloc_rd_i,
	input  logic                         alloc_pred_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] alloc_target_i,
	input  logic                         alloc_reg_write_i,
	input  logic                         wr_valid_i,
	input  rob_cfg_pkg::rob_tag_t        wr_tag_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] res_data_i,
	input  logic                         res_redirect_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] res_pc_i,
	output logic                         full_o,
	output rob_cfg_pkg::rob_tag_t        tail_o,
	output rob_isa_pkg::opcode_t         ent_opcode_o,
	output logic [rob_cfg_pkg::XLEN-1:0] ent_pc_o,
	output logic                         ent_pred_o,
	output logic [rob_cfg_pkg::XLEN-1:0] ent_target_o,
	output logic                         commit_valid_o,
	output logic [4:0]                   commit_rd_o,
	output logic [rob_cfg_pkg::XLEN-1:0] commit_data_o,
	output logic                         commit_reg_write_o,
	output logic                         flush_o,
	output logic [rob_cfg_pkg::XLEN-1:0] flush_pc_o
);
	import rob_cfg_pkg::*;
	import rob_isa_pkg::*;

	// per-entry control flags
	logic [depth-1:0] valid_q;
	logic [depth-1:0] done_q;
	logic [depth-1:0] redir_q;

	// per-entry payload
	opcode_t         opcode_q [depth];
	logic [XLEN-1:0] pc_q [depth];
	logic [4:0]      rd_q [depth];
	logic            pred_q [depth];
	logic [XLEN-1:0] target_q [depth];
	logic            regw_q [depth];
	logic [XLEN-1:0] data_q [depth];
	logic [XLEN-1:0] redir_pc_q [depth];

	rob_tag_t head_q;
	rob_tag_t tail_q;
	rob_cnt_t count_q;
	logic     wr_hit;

	function automatic rob_tag_t ptr_next(rob_tag_t p);
		if (int'(p) == depth - 1)
			return '0;
		return p + 1'b1;
	endfunction

	// completions for stale or empty slots are dropped
	assign wr_hit = wr_valid_i && valid_q[wr_tag_i];

	assign ent_opcode_o = opcode_q[wr_tag_i];
	assign ent_pc_o     = pc_q[wr_tag_i];
	assign ent_pred_o   = pred_q[wr_tag_i];
	assign ent_target_o = target_q[wr_tag_i];

	assign commit_valid_o     = valid_q[head_q] && done_q[head_q];
	assign commit_rd_o        = rd_q[head_q];
	assign commit_data_o      = data_q[head_q];
	assign commit_reg_write_o = regw_q[head_q];
	assign flush_o            = commit_valid_o && redir_q[head_q];
	assign flush_pc_o         = redir_pc_q[head_q];

	// a retiring head frees its slot for a dispatch in the same cycle
	assign full_o = (count_q == rob_cnt_t'(depth)) && !commit_valid_o;
	assign tail_o = tail_q;

	always_ff @(posedge clk) begin
		if (rst || flush_o) begin
			valid_q <= '0;
			done_q  <= '0;
			redir_q <= '0;
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (wr_hit) begin
				done_q[wr_tag_i]  <= 1'b1;
				redir_q[wr_tag_i] <= res_redirect_i;
			end
			if (commit_valid_o) begin
				valid_q[head_q] <= 1'b0;
				head_q          <= ptr_next(head_q);
			end
			// alloc comes last since it may land on the slot the head just left
			if (alloc_i) begin
				valid_q[tail_q] <= 1'b1;
				done_q[tail_q]  <= 1'b0;
				redir_q[tail_q] <= 1'b0;
				tail_q          <= ptr_next(tail_q);
			end
			count_q <= count_q + rob_cnt_t'(alloc_i) - rob_cnt_t'(commit_valid_o);
		end
	end

	always_ff @(posedge clk) begin
		if (alloc_i) begin
			opcode_q[tail_q] <= alloc_opcode_i;
			pc_q[tail_q]     <= alloc_pc_i;
			rd_q[tail_q]     <= alloc_rd_i;
			pred_q[tail_q]   <= alloc_pred_i;
			target_q[tail_q] <= alloc_target_i;
			regw_q[tail_q]   <= alloc_reg_write_i;
		end
		if (wr_hit) begin
			data_q[wr_tag_i]     <= res_data_i;
			redir_pc_q[wr_tag_i] <= res_pc_i;
		end
	end

endmodule

// ==== hdl/rob_branch_resolve.sv ====
`timescale 1ns/1ps

module rob_branch_resolve (
	input  logic                         wr_valid_i,
	input  logic                         wr_is_br_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] wr_data_i,
	input  logic                         wr_taken_i,
	input  rob_isa_pkg::opcode_t         ent_opcode_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] ent_pc_i,
	input  logic                         ent_pred_i,
	input  logic [rob_cfg_pkg::XLEN-1:0] ent_target_i,
	output logic [rob_cfg_pkg::XLEN-1:0] res_data_o,
	output logic                         res_redirect_o,
	output logic [rob_cfg_pkg::XLEN-1:0] res_pc_o
);
	import rob_cfg_pkg::*;
	import rob_isa_pkg::*;

	logic [XLEN-1:0] pc_plus4;

	assign pc_plus4 = ent_pc_i + XLEN'(4);

	always_comb begin
		res_data_o     = wr_data_i;
		res_redirect_o = 1'b0;
		res_pc_o       = pc_plus4;
		case (ent_opcode_i)
			op_jal: res_data_o = pc_plus4;
			op_jalr: begin
				// link value goes to rd and the computed target becomes the redirect
				res_data_o     = pc_plus4;
				res_redirect_o = wr_valid_i;
				res_pc_o       = wr_data_i;
			end
			op_br: begin
				// taken bit only comes from the branch unit
				res_redirect_o = wr_valid_i && wr_is_br_i && (wr_taken_i != ent_pred_i);
				res_pc_o       = wr_taken_i ? ent_target_i : pc_plus4;
			end
			default: res_redirect_o = 1'b0;
		endcase
	end

endmodule

// ==== hdl/rob_cdb_arbiter.sv ====
`timescale 1ns/1ps

module rob_cdb_arbiter #(
	parameter int depth = rob_cfg_pkg::ROB_DEPTH
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [2:0]                     req_i,
	input  rob_cfg_pkg::rob_tag_t          tag_i [3],
	input  logic [rob_cfg_pkg::XLEN-1:0]   data_i [3],
	input  logic                           taken_i,
	output logic [2:0]                     gnt_o,
	output logic                           wr_valid_o,
	output rob_cfg_pkg::rob_tag_t          wr_tag_o,
	output logic [rob_cfg_pkg::XLEN-1:0]   wr_data_o,
	output logic                           wr_is_br_o,
	output logic                           wr_taken_o
);
	import rob_isa_pkg::*;

	logic [1:0] last_q;
	logic [1:0] sel;
	logic       found;

	// search starts at the source after the last winner
	always_comb begin
		int idx;
		gnt_o = '0;
		sel   = last_q;
		found = 1'b0;
		for (int i = 1; i <= 3; i++) begin
			idx = (int'(last_q) + i) % 3;
			if (!found && req_i[idx]) begin
				found = 1'b1;
				sel   = 2'(idx);
			end
		end
		if (found)
			gnt_o[sel] = 1'b1;
	end

	// a tag past the last entry is acked but never written
	assign wr_valid_o = found && (int'(tag_i[sel]) < depth);
	assign wr_tag_o   = tag_i[sel];
	assign wr_data_o  = data_i[sel];
	assign wr_is_br_o = found && (int'(sel) == SRC_BR);
	assign wr_taken_o = taken_i && wr_is_br_o;

	// alu gets first pick out of reset
	always_ff @(posedge clk) begin
		if (rst) begin
			last_q <= 2'(SRC_LSQ);
		end else if (found) begin
			last_q <= sel;
		end
	end

endmodule

// ==== hdl/rob_dispatch.sv ====
`timescale 1ns/1ps

module rob_dispatch (
	input  logic                 disp_valid_i,
	input  rob_isa_pkg::opcode_t disp_opcode_i,
	input  logic                 stall_alu_i,
	input  logic                 stall_br_i,
	input  logic                 stall_lsq_i,
	input  logic                 full_i,
	input  logic                 flush_i,
	output logic                 disp_ready_o,
	output logic                 alloc_o,
	output logic                 load_alu_o,
	output logic                 load_br_o,
	output logic                 load_lsq_o,
	output logic                 reg_write_o
);
	import rob_isa_pkg::*;

	unit_e unit;
	logic  has_rd;
	logic  stalled;

	// station class and destination use of the opcode
	always_comb begin
		unit   = unit_alu;
		has_rd = 1'b1;
		case (disp_opcode_i)
			op_jal, op_jalr: unit = unit_br;
			op_br: begin
				unit   = unit_br;
				has_rd = 1'b0;
			end
			op_load: unit = unit_lsq;
			op_store: begin
				unit   = unit_lsq;
				has_rd = 1'b0;
			end
			default: unit = unit_alu;
		endcase
	end

	// only the target station's stall matters
	always_comb begin
		case (unit)
			unit_br:  stalled = stall_br_i;
			unit_lsq: stalled = stall_lsq_i;
			default:  stalled = stall_alu_i;
		endcase
	end

	// nothing enters while the buffer is being flushed
	assign disp_ready_o = !full_i && !flush_i && !stalled;
	assign alloc_o      = disp_valid_i && disp_ready_o;

	assign load_alu_o  = alloc_o && (unit == unit_alu);
	assign load_br_o   = alloc_o && (unit == unit_br);
	assign load_lsq_o  = alloc_o && (unit == unit_lsq);
	assign reg_write_o = alloc_o && has_rd;

endmodule

// ==== hdl/rob_isa_pkg.sv ====
package rob_isa_pkg;

	// rv32i major opcodes seen at dispatch
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} opcode_t;

	// reservation station class of an instruction
	typedef enum logic [1:0] {
		unit_alu = 2'd0,
		unit_br  = 2'd1,
		unit_lsq = 2'd2
	} unit_e;

	// completion source slots on the arbiter
	localparam int SRC_ALU = 0;
	localparam int SRC_BR  = 1;
	localparam int SRC_LSQ = 2;

endpackage

// ==== hdl/rob_cfg_pkg.sv ====
package rob_cfg_pkg;

	// default number of entries in the buffer
	localparam int ROB_DEPTH = 8;

	// data and pc width
	localparam int XLEN = 32;

	// entry index that execution units also report back as their tag
	typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

	// occupancy from empty up to ROB_DEPTH inclusive
	typedef logic [$clog2(ROB_DEPTH+1)-1:0] rob_cnt_t;

endpackage
